//--- source/spi_flash_consts.svh
`ifndef SPI_FLASH_CONSTS_SVH
`define SPI_FLASH_CONSTS_SVH

// Data word on the CPU side and in the reply
`define SPI_DATA_W 32

// Full address, low 24 bits used in three-byte mode
`define SPI_ADDR_W 32

// Flash opcode
`define SPI_CMD_W 8

// Opcode, 32-bit address and 32-bit data back to back
`define SPI_FRAME_W 72

// Bit counters, wide enough for the longest frame
`define SPI_BITCNT_W 7

// Half period of sclk in clk cycles
`define SPI_CLK_DIV_DEF 2

`endif

//--- source/spi_flash_pkg.sv
`default_nettype none
`include "spi_flash_consts.svh"

package spi_flash_pkg;

	typedef logic [`SPI_DATA_W-1:0]   data_t;
	typedef logic [`SPI_ADDR_W-1:0]   addr_t;
	typedef logic [`SPI_CMD_W-1:0]    cmd_t;
	typedef logic [`SPI_FRAME_W-1:0]  frame_t;
	typedef logic [`SPI_BITCNT_W-1:0] bitcnt_t;

	// Request kinds, codes 6 and 7 fall back to opcode only
	typedef enum logic [2:0] {
		CT_CMD           = 3'd0,
		CT_CMD_READ      = 3'd1,
		CT_CMD_ADDR_READ = 3'd2,
		CT_CMD_DATA      = 3'd3,
		CT_CMD_ADDR_DATA = 3'd4,
		CT_CMD_ADDR      = 3'd5
	} cmd_type_e;

	typedef enum logic [1:0] {
		IDLE,
		SETUP,
		TRANSFER
	} ctrl_state_e;

	// Types that expect an answer on miso
	function automatic logic is_read_type(cmd_type_e t);
		return (t == CT_CMD_READ) || (t == CT_CMD_ADDR_READ);
	endfunction

endpackage

`default_nettype wire

//--- source/spi_xfer_if.sv
`timescale 1ns/10ps
`default_nettype none

// Frame and lengths handed from the frame builder to the shift side
interface spi_xfer_if
	import spi_flash_pkg::*;
();

	// Left aligned, opcode in the top byte
	frame_t  frame;

	// Bits to send, then bits to receive
	bitcnt_t mosi_bits;
	bitcnt_t miso_bits;

	// High for the one cycle after a new frame is registered
	logic    build_done;

	modport builder (
		output frame,
		output mosi_bits,
		output miso_bits,
		output build_done
	);

	modport engine (
		input frame,
		input mosi_bits,
		input miso_bits,
		input build_done
	);

endinterface

`default_nettype wire

//--- source/spi_frame_builder.sv
`timescale 1ns/10ps
`default_nettype none
`include "spi_flash_consts.svh"

module spi_frame_builder
	import spi_flash_pkg::*;
(
	input wire            clk,
	input wire            rst,
	input wire            setup,
	input wire data_t     data_in,
	input wire addr_t     address,
	input wire cmd_t      command,
	input wire cmd_type_e cmd_type,
	input wire bitcnt_t   nmiso_bits,
	input wire            addr_4byte,
	spi_xfer_if.builder   xfer
);

	localparam int TAIL_W  = `SPI_FRAME_W - `SPI_CMD_W;
	localparam int ADDR3_W = 24;

	logic    has_addr;
	logic    has_data;
	frame_t  frame_d;
	bitcnt_t mosi_d;

	// Which fields follow the opcode
	assign has_addr = (cmd_type == CT_CMD_ADDR_READ) || (cmd_type == CT_CMD_ADDR_DATA) ||
		(cmd_type == CT_CMD_ADDR);
	assign has_data = (cmd_type == CT_CMD_DATA) || (cmd_type == CT_CMD_ADDR_DATA);

	always_comb begin
		frame_d = '0;
		frame_d[`SPI_FRAME_W-1 -: `SPI_CMD_W] = command;
		mosi_d = bitcnt_t'(`SPI_CMD_W);
		if (has_addr && addr_4byte) begin
			frame_d[TAIL_W-1 -: `SPI_ADDR_W] = address;
			if (has_data)
				frame_d[TAIL_W-`SPI_ADDR_W-1 -: `SPI_DATA_W] = data_in;
			mosi_d = mosi_d + bitcnt_t'(`SPI_ADDR_W);
		end else if (has_addr) begin
			frame_d[TAIL_W-1 -: ADDR3_W] = address[ADDR3_W-1:0];
			if (has_data)
				frame_d[TAIL_W-ADDR3_W-1 -: `SPI_DATA_W] = data_in;
			mosi_d = mosi_d + bitcnt_t'(ADDR3_W);
		end else if (has_data) begin
			// Data right behind the opcode
			frame_d[TAIL_W-1 -: `SPI_DATA_W] = data_in;
		end
		if (has_data)
			mosi_d = mosi_d + bitcnt_t'(`SPI_DATA_W);
	end

	always_ff @(posedge clk) begin
		if (setup)
			xfer.frame <= frame_d;
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			xfer.mosi_bits  <= '0;
			xfer.miso_bits  <= '0;
			xfer.build_done <= 1'b0;
		end else begin
			xfer.build_done <= setup;
			if (setup) begin
				xfer.mosi_bits <= mosi_d;
				xfer.miso_bits <= is_read_type(cmd_type) ? nmiso_bits : '0;
			end
		end
	end

	// A read with no reply bits would hang the receive phase
	a_read_bits: assert property (@(posedge clk) disable iff (rst)
		setup && is_read_type(cmd_type) |=> xfer.miso_bits != '0);

endmodule

`default_nettype wire

//--- source/spi_sclk_gen.sv
`timescale 1ns/10ps
`default_nettype none
`include "spi_flash_consts.svh"

module spi_sclk_gen #(
	parameter int CLK_DIV = `SPI_CLK_DIV_DEF
) (
	input wire         clk,
	input wire         rst,
	input wire         run,
	spi_xfer_if.engine xfer,
	output logic       sclk,
	output logic       fall_stb,
	output logic       rise_stb,
	output logic       edges_done
);

	localparam int DIV_W  = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;
	localparam int EDGE_W = `SPI_BITCNT_W + 2;

	logic [DIV_W-1:0]  div_cnt;
	logic [EDGE_W-1:0] edge_total;
	logic [EDGE_W-1:0] edge_cnt;
	logic [EDGE_W-1:0] edges_left;
	logic              phase;
	logic              tick;

	// Two edges per bit, sent and received
	assign edge_total = (EDGE_W'(xfer.mosi_bits) + EDGE_W'(xfer.miso_bits)) << 1;

	// Count is loaded while the new frame is announced
	assign edges_left = xfer.build_done ? edge_total : edge_cnt;

	assign tick     = run && (edges_left != '0) && (div_cnt == DIV_W'(CLK_DIV - 1));
	assign fall_stb = tick && !phase;
	assign rise_stb = tick && phase;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			div_cnt    <= '0;
			edge_cnt   <= '0;
			phase      <= 1'b0;
			sclk       <= 1'b0;
			edges_done <= 1'b0;
		end else begin
			edges_done <= tick && (edges_left == EDGE_W'(1));
			if (!run) begin
				div_cnt  <= '0;
				edge_cnt <= '0;
				phase    <= 1'b0;
				sclk     <= 1'b0;
			end else begin
				if (div_cnt == DIV_W'(CLK_DIV - 1))
					div_cnt <= '0;
				else
					div_cnt <= div_cnt + 1'b1;
				edge_cnt <= edges_left - EDGE_W'(tick);
				if (tick) begin
					// Low on the first edge of a bit, high on the second
					sclk  <= phase;
					phase <= !phase;
				end else if (edges_left == '0) begin
					sclk <= 1'b0;
				end
			end
		end
	end

	// Clock must already be parked low whenever the controller is idle
	a_sclk_idle: assert property (@(posedge clk) disable iff (rst)
		!run |-> !sclk);

endmodule

`default_nettype wire

//--- source/spi_shift_engine.sv
`timescale 1ns/10ps
`default_nettype none
`include "spi_flash_consts.svh"

module spi_shift_engine
	import spi_flash_pkg::*;
(
	input wire         clk,
	input wire         rst,
	input wire         start,
	input wire         fall_stb,
	input wire         rise_stb,
	spi_xfer_if.engine xfer,
	input wire         miso,
	output logic       mosi,
	output data_t      reply
);

	localparam int RX_IDX_W = $clog2(`SPI_DATA_W);

	bitcnt_t tx_cnt;
	bitcnt_t tx_rise_cnt;
	bitcnt_t rx_cnt;
	bitcnt_t tx_idx;
	logic    tx_more;
	logic    rx_take;

	// MSB first from the top of the frame
	assign tx_idx  = bitcnt_t'(`SPI_FRAME_W - 1) - tx_cnt;
	assign tx_more = (tx_cnt != xfer.mosi_bits);

	// Receive only once every sent bit has had its rising edge
	assign rx_take = rise_stb && (tx_rise_cnt == xfer.mosi_bits) &&
		(rx_cnt != xfer.miso_bits);

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			tx_cnt      <= '0;
			tx_rise_cnt <= '0;
			rx_cnt      <= '0;
			mosi        <= 1'b0;
		end else if (start) begin
			tx_cnt      <= '0;
			tx_rise_cnt <= '0;
			rx_cnt      <= '0;
			mosi        <= 1'b0;
		end else begin
			if (fall_stb) begin
				if (tx_more) begin
					mosi   <= xfer.frame[tx_idx];
					tx_cnt <= tx_cnt + 1'b1;
				end else begin
					mosi <= 1'b0;
				end
			end
			if (rise_stb && (tx_rise_cnt != xfer.mosi_bits))
				tx_rise_cnt <= tx_rise_cnt + 1'b1;
			if (rx_take)
				rx_cnt <= rx_cnt + 1'b1;
		end
	end

	// First received bit in bit 0, unused upper bits stay zero
	always_ff @(posedge clk) begin
		if (start)
			reply <= '0;
		else if (rx_take)
			reply[rx_cnt[RX_IDX_W-1:0]] <= miso;
	end

endmodule

`default_nettype wire

//--- source/spi_flash_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module spi_flash_ctrl
	import spi_flash_pkg::*;
(
	input wire            clk,
	input wire            rst,
	input wire            valid,
	input wire            build_done,
	input wire            edges_done,
	input wire data_t     reply,
	input wire cmd_type_e cmd_type,
	output logic          setup,
	output logic          run,
	output logic          ss,
	output logic          tready,
	output data_t         data_out,
	output logic          valid_out
);

	ctrl_state_e state;
	logic        valid_q;
	logic        expect_answer;

	// New request only on a rising valid while idle
	assign setup = (state == IDLE) && valid && !valid_q;

	// Divider runs from SETUP so its first half period lines up with ss falling
	assign run = (state == SETUP) || (state == TRANSFER);

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state         <= IDLE;
			valid_q       <= 1'b0;
			expect_answer <= 1'b0;
			ss            <= 1'b1;
			tready        <= 1'b1;
			data_out      <= '0;
			valid_out     <= 1'b0;
		end else begin
			valid_q   <= valid;
			valid_out <= 1'b0;
			case (state)
				IDLE: begin
					if (setup) begin
						expect_answer <= is_read_type(cmd_type);
						tready        <= 1'b0;
						state         <= SETUP;
					end
				end
				SETUP: begin
					if (build_done) begin
						ss    <= 1'b0;
						state <= TRANSFER;
					end
				end
				TRANSFER: begin
					if (edges_done) begin
						ss        <= 1'b1;
						tready    <= 1'b1;
						data_out  <= reply;
						valid_out <= expect_answer;
						state     <= IDLE;
					end
				end
				default: begin
					ss     <= 1'b1;
					tready <= 1'b1;
					state  <= IDLE;
				end
			endcase
		end
	end

	// Slave select belongs to the transfer state alone
	a_ss_transfer: assert property (@(posedge clk) disable iff (rst)
		!ss |-> state == TRANSFER);

	// Never ready for a new request while the flash is selected
	a_ready_ss: assert property (@(posedge clk) disable iff (rst)
		!(tready && !ss));

endmodule

`default_nettype wire

//--- source/spi_flash_master.sv
`timescale 1ns/10ps
`default_nettype none
`include "spi_flash_consts.svh"

module spi_flash_master
	import spi_flash_pkg::*;
#(
	parameter int CLK_DIV = `SPI_CLK_DIV_DEF
) (
	input wire            clk,
	input wire            rst,
	input wire data_t     data_in,
	input wire addr_t     address,
	input wire cmd_t      command,
	input wire cmd_type_e cmd_type,
	input wire bitcnt_t   nmiso_bits,
	input wire            addr_4byte,
	input wire            valid,
	output data_t         data_out,
	output logic          valid_out,
	output logic          tready,
	output logic          sclk,
	output logic          ss,
	output logic          mosi,
	input wire            miso
);

	logic  setup;
	logic  run;
	logic  fall_stb;
	logic  rise_stb;
	logic  edges_done;
	data_t reply;

	spi_xfer_if xfer ();

	spi_frame_builder frame_builder_i (
		.clk        (clk),
		.rst        (rst),
		.setup      (setup),
		.data_in    (data_in),
		.address    (address),
		.command    (command),
		.cmd_type   (cmd_type),
		.nmiso_bits (nmiso_bits),
		.addr_4byte (addr_4byte),
		.xfer       (xfer.builder)
	);

	spi_sclk_gen #(
		.CLK_DIV (CLK_DIV)
	) sclk_gen_i (
		.clk        (clk),
		.rst        (rst),
		.run        (run),
		.xfer       (xfer.engine),
		.sclk       (sclk),
		.fall_stb   (fall_stb),
		.rise_stb   (rise_stb),
		.edges_done (edges_done)
	);

	// Setup pulse also clears the engine for the coming frame
	spi_shift_engine shift_engine_i (
		.clk      (clk),
		.rst      (rst),
		.start    (setup),
		.fall_stb (fall_stb),
		.rise_stb (rise_stb),
		.xfer     (xfer.engine),
		.miso     (miso),
		.mosi     (mosi),
		.reply    (reply)
	);

	spi_flash_ctrl flash_ctrl_i (
		.clk        (clk),
		.rst        (rst),
		.valid      (valid),
		.build_done (xfer.build_done),
		.edges_done (edges_done),
		.reply      (reply),
		.cmd_type   (cmd_type),
		.setup      (setup),
		.run        (run),
		.ss         (ss),
		.tready     (tready),
		.data_out   (data_out),
		.valid_out  (valid_out)
	);

endmodule

`default_nettype wire

//--- testbench/spi_flash_model.sv
`timescale 1ns/10ps
`default_nettype none
`include "spi_flash_consts.svh"

module spi_flash_model
	import spi_flash_pkg::*;
(
	input wire          sclk,
	input wire          ss,
	input wire          mosi,
	input wire bitcnt_t mosi_bits,
	input wire data_t   reply_word,
	output logic        miso,
	output frame_t      frame_seen,
	output bitcnt_t     rise_count
);

	int rx_idx;

	initial begin
		miso       = 1'b0;
		frame_seen = '0;
		rise_count = '0;
		rx_idx     = 0;
	end

	// Selecting the flash starts a fresh frame
	always @(negedge ss) begin
		frame_seen = '0;
		rise_count = '0;
		rx_idx     = 0;
	end

	// Command bits arrive left aligned, like the frame itself
	always @(posedge sclk) begin
		if (!ss) begin
			if (rise_count < mosi_bits)
				frame_seen[`SPI_FRAME_W - 1 - int'(rise_count)] = mosi;
			rise_count = rise_count + 1'b1;
		end
	end

	// Answer starts on the falling edge after the last command bit
	always @(negedge sclk) begin
		if (!ss && (rise_count >= mosi_bits) && (rx_idx < `SPI_DATA_W)) begin
			miso <= reply_word[rx_idx];
			rx_idx = rx_idx + 1;
		end
	end

endmodule

`default_nettype wire

//--- testbench/tb_spi_flash_master.sv
`timescale 1ns/10ps
`default_nettype none
`include "spi_flash_consts.svh"

module tb_spi_flash_master
	import spi_flash_pkg::*;
();

	localparam int CLK_DIV  = `SPI_CLK_DIV_DEF;
	localparam int NUM_REQ  = 200;
	localparam int MAX_BITS = 104;
	// Request edge, setup, longest transfer and some slack per request
	localparam int TIMEOUT_CYCLES = NUM_REQ * (1 + 1 + MAX_BITS * 2 * CLK_DIV + 10) + 20;

	logic      clk;
	logic      rst;
	data_t     data_in;
	addr_t     address;
	cmd_t      command;
	cmd_type_e cmd_type;
	bitcnt_t   nmiso_bits;
	logic      addr_4byte;
	logic      valid;
	data_t     data_out;
	logic      valid_out;
	logic      tready;
	logic      sclk;
	logic      ss;
	logic      mosi;
	logic      miso;

	bitcnt_t   model_mosi_bits;
	data_t     model_reply;
	frame_t    frame_seen;
	bitcnt_t   rise_count;

	integer    seed;
	int        cycle_count;
	int        ss_low_cycles;
	int        valid_out_pulses;

	initial clk = 1'b0;
	always #20 clk = ~clk;

	spi_flash_master #(
		.CLK_DIV (CLK_DIV)
	) spi_flash_master_i (
		.clk        (clk),
		.rst        (rst),
		.data_in    (data_in),
		.address    (address),
		.command    (command),
		.cmd_type   (cmd_type),
		.nmiso_bits (nmiso_bits),
		.addr_4byte (addr_4byte),
		.valid      (valid),
		.data_out   (data_out),
		.valid_out  (valid_out),
		.tready     (tready),
		.sclk       (sclk),
		.ss         (ss),
		.mosi       (mosi),
		.miso       (miso)
	);

	spi_flash_model flash_model_i (
		.sclk       (sclk),
		.ss         (ss),
		.mosi       (mosi),
		.mosi_bits  (model_mosi_bits),
		.reply_word (model_reply),
		.miso       (miso),
		.frame_seen (frame_seen),
		.rise_count (rise_count)
	);

	task automatic abort_run(input string what);
		$display("%s", what);
		$display("*** FAILED ***");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_bit(input string name, input logic expected, input logic actual);
		if (actual !== expected)
			abort_run($sformatf("mismatch %s: expected %b, actual %b", name, expected, actual));
	endtask

	task automatic check_data(input string name, input data_t expected, input data_t actual);
		if (actual !== expected)
			abort_run($sformatf("mismatch %s: expected %h, actual %h", name, expected, actual));
	endtask

	task automatic check_frame(input string name, input frame_t expected, input frame_t actual);
		if (actual !== expected)
			abort_run($sformatf("mismatch %s: expected %h, actual %h", name, expected, actual));
	endtask

	task automatic check_count(input string name, input bitcnt_t expected,
		input bitcnt_t actual);
		if (actual !== expected)
			abort_run($sformatf("mismatch %s: expected %0d, actual %0d", name, expected, actual));
	endtask

	// Frame, send length and receive length from the command type rules
	task automatic predict(input logic [2:0] code, input cmd_t cmd, input addr_t addr,
		input data_t data, input logic four_byte, input bitcnt_t nmiso,
		output frame_t frame, output bitcnt_t tx_bits, output bitcnt_t rx_bits);
		logic reads;
		logic addr_on;
		logic data_on;
		int   addr_len;
		int   len;
		reads    = (code == 3'd1) || (code == 3'd2);
		addr_on  = (code == 3'd2) || (code == 3'd4) || (code == 3'd5);
		data_on  = (code == 3'd3) || (code == 3'd4);
		addr_len = four_byte ? 32 : 24;
		frame    = frame_t'(cmd);
		len      = 8;
		if (addr_on) begin
			frame = (frame << addr_len) |
				(frame_t'(addr) & ((frame_t'(1) << addr_len) - 1'b1));
			len = len + addr_len;
		end
		if (data_on) begin
			frame = (frame << 32) | frame_t'(data);
			len   = len + 32;
		end
		// Opcode ends up in the top byte
		frame   = frame << (`SPI_FRAME_W - len);
		tx_bits = bitcnt_t'(len);
		rx_bits = reads ? nmiso : '0;
	endtask

	// Only the first nbits answer bits survive, first one in bit 0
	function automatic data_t expected_reply(input data_t word, input bitcnt_t nbits);
		data_t r;
		r = '0;
		for (int i = 0; i < `SPI_DATA_W; i++)
			if (i < nbits)
				r[i] = word[i];
		return r;
	endfunction

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES)
			abort_run("timeout: the DUT did not finish its transfers in time");
	end

	// Outputs are settled by the falling clock edge
	always @(negedge clk) begin
		if (!ss)
			ss_low_cycles = ss_low_cycles + 1;
		if (valid_out)
			valid_out_pulses = valid_out_pulses + 1;
	end

	initial begin
		logic [31:0] rnd;
		logic [2:0]  code;
		logic        four_byte;
		bitcnt_t     nbits;
		cmd_t        cmd_v;
		addr_t       addr_v;
		data_t       data_v;
		data_t       reply_v;
		frame_t      exp_frame;
		bitcnt_t     exp_tx;
		bitcnt_t     exp_rx;
		int          period;
		seed             = 40812;
		period           = 2 * CLK_DIV;
		cycle_count      = 0;
		ss_low_cycles    = 0;
		valid_out_pulses = 0;
		rst              = 1'b1;
		data_in          = '0;
		address          = '0;
		command          = '0;
		cmd_type         = CT_CMD;
		nmiso_bits       = '0;
		addr_4byte       = 1'b0;
		valid            = 1'b0;
		model_mosi_bits  = '0;
		model_reply      = '0;
		repeat (4) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		check_bit("ss after reset", 1'b1, ss);
		check_bit("sclk after reset", 1'b0, sclk);
		check_bit("tready after reset", 1'b1, tready);
		check_bit("valid_out after reset", 1'b0, valid_out);
		check_bit("mosi after reset", 1'b0, mosi);
		check_data("data_out after reset", '0, data_out);

		for (int n = 0; n < NUM_REQ; n++) begin
			rnd       = $random(seed);
			code      = rnd[2:0];
			four_byte = rnd[3];
			nbits     = bitcnt_t'(rnd[8:4]) + 1'b1;
			cmd_v     = rnd[23:16];
			addr_v    = $random(seed);
			data_v    = $random(seed);
			reply_v   = $random(seed);
			predict(code, cmd_v, addr_v, data_v, four_byte, nbits, exp_frame, exp_tx, exp_rx);
			model_mosi_bits  = exp_tx;
			model_reply      = reply_v;
			ss_low_cycles    = 0;
			valid_out_pulses = 0;

			@(posedge clk);
			command    <= cmd_v;
			address    <= addr_v;
			data_in    <= data_v;
			cmd_type   <= cmd_type_e'(code);
			addr_4byte <= four_byte;
			nmiso_bits <= nbits;
			valid      <= 1'b1;
			while (ss)
				@(negedge clk);

			// New edge on valid and fresh inputs mid transfer must be ignored
			if (rnd[9]) begin
				@(posedge clk);
				rnd        = $random(seed);
				valid      <= 1'b0;
				command    <= rnd[31:24];
				cmd_type   <= cmd_type_e'(rnd[2:0]);
				addr_4byte <= rnd[3];
				nmiso_bits <= bitcnt_t'(rnd[8:4]) + 1'b1;
				data_in    <= $random(seed);
				address    <= $random(seed);
				@(posedge clk);
				valid <= 1'b1;
			end
			while (!tready)
				@(negedge clk);

			// Reply, ss and valid_out all change together with tready
			check_bit("ss after transfer", 1'b1, ss);
			check_bit("valid_out with tready", exp_rx != '0, valid_out);
			check_data("data_out", expected_reply(reply_v, exp_rx), data_out);

			@(negedge clk);
			// Valid still high must not start another request
			check_bit("tready after transfer", 1'b1, tready);
			check_frame("mosi frame", exp_frame, frame_seen);
			check_count("sclk rising edges", exp_tx + exp_rx, rise_count);
			check_count("valid_out pulses", (exp_rx != '0) ? bitcnt_t'(1) : bitcnt_t'(0),
				bitcnt_t'(valid_out_pulses));
			check_count("ss low cycles past whole sclk periods", '0,
				bitcnt_t'(ss_low_cycles % period));
			check_count("ss low sclk periods", exp_tx + exp_rx,
				bitcnt_t'(ss_low_cycles / period));

			@(posedge clk);
			valid <= 1'b0;
		end

		repeat (2) @(negedge clk);
		$display("*** PASSED ***");
		$finish;
	end

endmodule

`default_nettype wire

//--- spi_flash_master.f
+incdir+source
source/spi_flash_pkg.sv
source/spi_xfer_if.sv
source/spi_frame_builder.sv
source/spi_sclk_gen.sv
source/spi_shift_engine.sv
source/spi_flash_ctrl.sv
source/spi_flash_master.sv
testbench/spi_flash_model.sv
testbench/tb_spi_flash_master.sv

//--- Bender.yml
package:
  name: spi_flash_master

sources:
  - include_dirs:
      - source
    files:
      - source/spi_flash_pkg.sv
      - source/spi_xfer_if.sv
      - source/spi_frame_builder.sv
      - source/spi_sclk_gen.sv
      - source/spi_shift_engine.sv
      - source/spi_flash_ctrl.sv
      - source/spi_flash_master.sv
  - target: test
    include_dirs:
      - source
    files:
      - testbench/spi_flash_model.sv
      - testbench/tb_spi_flash_master.sv
